// ==== tb/dram_stage_vectors.txt ====
# kind and hex fields: fill sec data | rfill sec n | issue addr count sec
# expect_sent n | peek col data | mpeek col, checked against the model alone
expect_sent 00
peek 000 00000000
fill 0 1111
fill 0 2222
fill 0 3333
fill 0 4444
issue 010 04 0
expect_sent 04
peek 008 22221111
peek 009 44443333
fill 1 aaaa
fill 1 bbbb
fill 1 cccc
issue 011 03 1
expect_sent 03
peek 008 aaaa1111
peek 009 ccccbbbb
fill 2 5555
fill 2 6666
fill 2 7777
issue 010 03 2
expect_sent 03
peek 008 66665555
peek 009 cccc7777
fill 3 9999
fill 3 8888
fill 3 7770
issue 040 06 3
expect_sent 03
peek 020 88889999
peek 021 00007770
fill 0 a001
fill 1 b001
fill 0 a002
fill 1 b002
issue 100 02 0
issue 102 02 1
expect_sent 02
peek 080 a002a001
peek 081 b002b001
rfill 2 05
issue 201 05 2
expect_sent 05
mpeek 100
mpeek 101
fill 0 5a5a
issue 300 00 0
expect_sent 00
peek 180 00000000
issue 300 01 0
expect_sent 01
peek 180 00005a5a

// ==== sources.f ====
+incdir+include
hdl/dram_stage_pkg.sv
hdl/lsab_sections.sv
hdl/block_mover_todram.sv
hdl/column_dram.sv
hdl/dram_stage_top.sv
tb/tb_dram_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_dram_stage \
	-o tb_dram_stage > build.log 2>&1 \
	&& ./obj_dir/tb_dram_stage > sim.log 2>&1 \
	|| { cat build.log; [ -f sim.log ] && cat sim.log; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// ==== tb/tb_dram_stage.sv ====
// Vector-driven testbench for the DRAM staging top level, run from tb/dram_stage_vectors.txt
`timescale 1ns/1ns
`default_nettype none

`include "dram_stage_defs.svh"

module tb_dram_stage;

	import dram_stage_pkg::*;

	logic                   CLK;
	logic                   RST;
	logic                   fill_write;
	section_t               fill_section;
	logic [`DS_HALF_W-1:0]  fill_data;
	logic [`DS_ADDR_W-1:0]  start_address;
	logic [`DS_COUNT_W-1:0] count;
	section_t               section;
	logic                   issue;
	logic [`DS_COUNT_W-1:0] count_sent;
	logic                   working;
	logic [`DS_ADDR_W-2:0]  peek_addr;
	logic [`DS_COL_W-1:0]   peek_data;

	string                 kind_q [$];
	int                    arg0_q [$];
	int                    arg1_q [$];
	int                    arg2_q [$];
	logic [`DS_COL_W-1:0]  ref_mem [`DS_DRAM_COLS];
	logic [`DS_HALF_W-1:0] ref_fifo [4][`DS_FIFO_DEPTH];
	int                    ref_head [4];
	int                    ref_level [4];
	int                    ref_sent;
	logic [31:0]           lcg_state;
	int                    errors;
	bit                    loaded;

	dram_stage_top UUT (
		.CLK           (CLK),
		.RST           (RST),
		.fill_write    (fill_write),
		.fill_section  (fill_section),
		.fill_data     (fill_data),
		.start_address (start_address),
		.count         (count),
		.section       (section),
		.issue         (issue),
		.count_sent    (count_sent),
		.working       (working),
		.peek_addr     (peek_addr),
		.peek_data     (peek_data)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];  // Upper bits of an LCG are the better ones
	endfunction

	task automatic load_vectors();
		int    fd;
		int    n;
		int    c;
		int    a0;
		int    a1;
		int    a2;
		string kind;
		fd = $fopen("tb/dram_stage_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("Error: the vector file could not be opened");
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			n = $fscanf(fd, "%s", kind);
			if (n != 1)
				break;
			a0 = 0;
			a1 = 0;
			a2 = 0;
			if (kind.getc(0) == 8'h23)
			begin
				c = 0;
				while (c != 10 && c != -1)
					c = $fgetc(fd);  // Skip the rest of a comment line
			end
			else
			begin
				case (kind)
					"issue": n = $fscanf(fd, "%h %h %h", a0, a1, a2);
					"expect_sent", "mpeek": n = $fscanf(fd, "%h", a0);
					default: n = $fscanf(fd, "%h %h", a0, a1);
				endcase
				kind_q.push_back(kind);
				arg0_q.push_back(a0);
				arg1_q.push_back(a1);
				arg2_q.push_back(a2);
			end
		end
		$fclose(fd);
	endtask

	task automatic do_fill(input int sec, input int data);
		@(negedge CLK);
		fill_write = 1'b1;
		fill_section = sec[1:0];
		fill_data = data[`DS_HALF_W-1:0];
		@(negedge CLK);
		fill_write = 1'b0;
		if (ref_level[sec] < `DS_FIFO_DEPTH)
		begin
			ref_fifo[sec][(ref_head[sec] + ref_level[sec]) % `DS_FIFO_DEPTH] = data[15:0];
			ref_level[sec]++;
		end
	endtask

	task automatic do_move(input int addr, input int cnt, input int sec);
		int                    a;
		logic [`DS_HALF_W-1:0] h;
		@(negedge CLK);
		start_address = addr[`DS_ADDR_W-1:0];
		count = cnt[`DS_COUNT_W-1:0];
		section = sec[1:0];
		issue = 1'b1;
		@(negedge CLK);
		issue = 1'b0;
		@(negedge CLK);
		if (working !== 1'b1)
		begin
			$display("FAILED %0t working expected 1 got %b", $time, working);
			errors++;
		end
		while (working)
			@(negedge CLK);
		repeat (2) @(negedge CLK);  // Last column write lands three cycles after the final read
		ref_sent = 0;
		a = addr;
		while (ref_sent < cnt && ref_level[sec] > 0)
		begin
			h = ref_fifo[sec][ref_head[sec]];
			ref_head[sec] = (ref_head[sec] + 1) % `DS_FIFO_DEPTH;
			ref_level[sec]--;
			if (a % 2 == 1)
				ref_mem[a / 2][31:16] = h;  // Odd halfword address is the high half
			else
				ref_mem[a / 2][15:0] = h;
			a = (a + 1) % (1 << `DS_ADDR_W);
			ref_sent++;
		end
	endtask

	task automatic check_sent(input int want);
		@(negedge CLK);
		if (want != ref_sent)
		begin
			$display("Error: vector file expects %0d halfwords sent, model gives %0d", want, ref_sent);
			errors++;
		end
		if (count_sent !== `DS_COUNT_W'(ref_sent))
		begin
			$display("FAILED %0t count_sent expected %0d got %0d", $time, ref_sent, count_sent);
			errors++;
		end
	endtask

	task automatic check_peek(input int col, input int want, input bit use_file);
		@(negedge CLK);
		peek_addr = col[`DS_ADDR_W-2:0];
		@(negedge CLK);
		if (use_file && want !== ref_mem[col])
		begin
			$display("Error: vector file expects %h in column %h, model holds %h",
				want, col, ref_mem[col]);
			errors++;
		end
		if (peek_data !== ref_mem[col])
		begin
			$display("FAILED %0t peek_data[%h] expected %h got %h", $time, col, ref_mem[col],
				peek_data);
			errors++;
		end
	endtask

	task automatic run_vector(input int i);
		case (kind_q[i])
			"fill": do_fill(arg0_q[i], arg1_q[i]);
			"rfill":
				for (int k = 0; k < arg1_q[i]; k++)
					do_fill(arg0_q[i], {16'h0, lcg_next()});
			"issue": do_move(arg0_q[i], arg1_q[i], arg2_q[i]);
			"expect_sent": check_sent(arg0_q[i]);
			"peek": check_peek(arg0_q[i], arg1_q[i], 1'b1);
			"mpeek": check_peek(arg0_q[i], 0, 1'b0);
			default:
			begin
				$display("Error: unknown vector kind %s", kind_q[i]);
				errors++;
			end
		endcase
	endtask

	// Watchdog sized from the number of vectors
	initial
	begin
		wait (loaded);
		repeat (kind_q.size() * 64 + 200) @(posedge CLK);
		$display("Error: the run did not finish in time");
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		RST = 1'b0;
		fill_write = 1'b0;
		fill_section = '0;
		fill_data = '0;
		start_address = '0;
		count = '0;
		section = '0;
		issue = 1'b0;
		peek_addr = '0;
		errors = 0;
		ref_sent = 0;
		loaded = 1'b0;
		lcg_state = 32'hefed80ab;
		for (int c = 0; c < `DS_DRAM_COLS; c++)
			ref_mem[c] = '0;
		for (int s = 0; s < 4; s++)
		begin
			ref_head[s] = 0;
			ref_level[s] = 0;
		end
		load_vectors();
		loaded = 1'b1;
		repeat (4) @(negedge CLK);
		RST = 1'b1;
		@(negedge CLK);
		if (working !== 1'b0)
		begin
			$display("FAILED %0t working expected 0 got %b", $time, working);
			errors++;
		end
		for (int i = 0; i < kind_q.size(); i++)
			run_vector(i);
		$display("Run over %0d vectors ended with %0d errors", kind_q.size(), errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/dram_stage_top.sv ====
// Top level of the staging subsystem, joining the LSAB sections, the mover and the column DRAM
`timescale 1ns/1ns
`default_nettype none

`include "dram_stage_defs.svh"

module dram_stage_top (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic                     fill_write,
	input  dram_stage_pkg::section_t fill_section,
	input  logic [`DS_HALF_W-1:0]    fill_data,
	input  logic [`DS_ADDR_W-1:0]    start_address,
	input  logic [`DS_COUNT_W-1:0]   count,
	input  dram_stage_pkg::section_t section,
	input  logic                     issue,
	output logic [`DS_COUNT_W-1:0]   count_sent,
	output logic                     working,
	input  logic [`DS_ADDR_W-2:0]    peek_addr,
	output logic [`DS_COL_W-1:0]     peek_data
);

	import dram_stage_pkg::*;

	logic [3:0]            empty;
	logic                  lsab_read;
	section_t              lsab_section;
	logic                  mover_half_odd;
	logic [`DS_HALF_W-1:0] rd_data;
	logic                  rd_valid;
	logic [`DS_ADDR_W-2:0] dram_addr;
	logic [3:0]            dram_we;
	logic                  dram_request;

	lsab_sections u_lsab (
		.CLK          (CLK),
		.RST          (RST),
		.fill_write   (fill_write),
		.fill_section (fill_section),
		.fill_data    (fill_data),
		.lsab_read    (lsab_read),
		.lsab_section (lsab_section),
		.empty        (empty),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid)
	);

	block_mover_todram u_mover (
		.CLK            (CLK),
		.RST            (RST),
		.empty          (empty),
		.lsab_read      (lsab_read),
		.lsab_section   (lsab_section),
		.mover_half_odd (mover_half_odd),
		.start_address  (start_address),
		.count          (count),
		.section        (section),
		.issue          (issue),
		.count_sent     (count_sent),
		.working        (working),
		.dram_addr      (dram_addr),
		.dram_we        (dram_we),
		.dram_request   (dram_request)
	);

	column_dram u_dram (
		.CLK            (CLK),
		.RST            (RST),
		.rd_data        (rd_data),
		.rd_valid       (rd_valid),
		.mover_half_odd (mover_half_odd),
		.dram_addr      (dram_addr),
		.dram_we        (dram_we),
		.dram_request   (dram_request),
		.peek_addr      (peek_addr),
		.peek_data      (peek_data)
	);

endmodule

`default_nettype wire

// ==== hdl/column_dram.sv ====
// Behavioural column DRAM that gathers LSAB halfwords into a column and stores it under a byte mask
`timescale 1ns/1ns
`default_nettype none

`include "dram_stage_defs.svh"

module column_dram (
	input  logic                  CLK,
	input  logic                  RST,
	input  logic [`DS_HALF_W-1:0] rd_data,
	input  logic                  rd_valid,
	input  logic                  mover_half_odd,
	input  logic [`DS_ADDR_W-2:0] dram_addr,
	input  logic [3:0]            dram_we,
	input  logic                  dram_request,
	input  logic [`DS_ADDR_W-2:0] peek_addr,
	output logic [`DS_COL_W-1:0]  peek_data
);

	import dram_stage_pkg::*;

	column_u                  col_reg;
	column_u                  old_col;
	column_u                  new_col;
	logic                     half_odd_q;
	logic [`DS_COL_W-1:0]     mem [`DS_DRAM_COLS];
	logic [`DS_DRAM_COLS-1:0] col_valid;

	// Half select lines up with the data one cycle after the read strobe
	always_ff @(posedge CLK)
	begin
		half_odd_q <= mover_half_odd;
		if (rd_valid)
			col_reg.half[half_odd_q] <= rd_data;
	end

	// Columns never written since reset read as zero
	assign old_col = col_valid[dram_addr] ? mem[dram_addr] : '0;

	always_comb
	begin
		for (int b = 0; b < 4; b++)
			new_col.lane[b] = dram_we[b] ? col_reg.lane[b] : old_col.lane[b];
	end

	always_ff @(posedge CLK)
	begin
		if (dram_request)
			mem[dram_addr] <= new_col;  // Every request is taken in the cycle it arrives
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
			col_valid <= '0;
		else if (dram_request)
			col_valid[dram_addr] <= 1'b1;
	end

	// Read-back port for the testbench
	assign peek_data = col_valid[peek_addr] ? mem[peek_addr] : '0;

endmodule

`default_nettype wire

// ==== hdl/block_mover_todram.sv ====
// Block mover that drains a counted run of halfwords from one LSAB section into masked DRAM column writes
`timescale 1ns/1ns
`default_nettype none

`include "dram_stage_defs.svh"

module block_mover_todram (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic [3:0]               empty,
	output logic                     lsab_read,
	output dram_stage_pkg::section_t lsab_section,
	output logic                     mover_half_odd,
	input  logic [`DS_ADDR_W-1:0]    start_address,
	input  logic [`DS_COUNT_W-1:0]   count,
	input  dram_stage_pkg::section_t section,
	input  logic                     issue,
	output logic [`DS_COUNT_W-1:0]   count_sent,
	output logic                     working,
	output logic [`DS_ADDR_W-2:0]    dram_addr,
	output logic [3:0]               dram_we,
	output logic                     dram_request
);

	logic                   busy;
	logic [`DS_ADDR_W-1:0]  track_addr;
	logic [`DS_COUNT_W-1:0] cmd_count;
	logic [`DS_COUNT_W-1:0] n_read;
	logic                   sel_empty;
	logic                   read_more;
	logic                   odd_done;
	logic                   flush;
	logic                   pre_request;
	logic [`DS_ADDR_W-2:0]  pre_addr;
	logic [3:0]             pre_we;

	assign sel_empty      = empty[lsab_section];
	assign read_more      = (n_read != cmd_count);
	assign lsab_read      = busy && !sel_empty && read_more;  // One halfword per busy cycle
	assign mover_half_odd = track_addr[0];
	assign odd_done       = lsab_read && track_addr[0];       // This read completes a column

	// A move that ends right after an even-address read leaves a lone low half behind
	assign flush = busy && !lsab_read && track_addr[0] && (n_read != '0);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			busy <= 1'b0;
			lsab_section <= '0;
			cmd_count <= '0;
			n_read <= '0;
			track_addr <= '0;
			count_sent <= '0;
		end
		else if (!busy)
		begin
			lsab_section <= section;  // Command is latched every idle cycle and issue starts it
			cmd_count <= count;
			n_read <= '0;
			track_addr <= start_address;
			busy <= issue;
		end
		else if (lsab_read)
		begin
			track_addr <= track_addr + 1'b1;
			n_read <= n_read + 1'b1;
		end
		else
		begin
			busy <= 1'b0;  // Section empty or count reached
			count_sent <= n_read;
		end
	end

	// Column address and mask travel with the request through a two-stage delay
	always_ff @(posedge CLK)
	begin
		if (odd_done)
		begin
			pre_addr <= track_addr[`DS_ADDR_W-1:1];
			pre_we <= {2'b11, {2{n_read != '0}}};  // Low half only if this move read it
		end
		if (flush)
			dram_addr <= track_addr[`DS_ADDR_W-1:1];
		else if (pre_request)
			dram_addr <= pre_addr;
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			pre_request <= 1'b0;
			dram_request <= 1'b0;
			dram_we <= '0;
			working <= 1'b0;
		end
		else
		begin
			pre_request <= odd_done;
			working <= busy;  // Lags busy by one cycle on both edges
			if (flush)
			begin
				dram_request <= 1'b1;  // Flush is already one cycle late, so skip the delay
				dram_we <= 4'b0011;
			end
			else
			begin
				dram_request <= pre_request;  // Gives the column register a cycle to take the data
				dram_we <= pre_request ? pre_we : 4'b0000;
			end
		end
	end

	// A flush takes priority in the request stage, so it must never meet a pending column write
	a_flush_alone: assert property (
		@(posedge CLK) disable iff (!RST)
		flush |-> !pre_request
	);

endmodule

`default_nettype wire

// ==== hdl/lsab_sections.sv ====
// Four halfword FIFOs of the load/store staging buffer, filled from outside and drained by the mover
`timescale 1ns/1ns
`default_nettype none

`include "dram_stage_defs.svh"

module lsab_sections (
	input  logic                     CLK,
	input  logic                     RST,
	input  logic                     fill_write,
	input  dram_stage_pkg::section_t fill_section,
	input  logic [`DS_HALF_W-1:0]    fill_data,
	input  logic                     lsab_read,
	input  dram_stage_pkg::section_t lsab_section,
	output logic [3:0]               empty,
	output logic [`DS_HALF_W-1:0]    rd_data,
	output logic                     rd_valid
);

	localparam int AW = $clog2(`DS_FIFO_DEPTH);

	logic [`DS_HALF_W-1:0] mem [4][`DS_FIFO_DEPTH];
	logic [AW-1:0]         wr_ptr [4];
	logic [AW-1:0]         rd_ptr [4];
	logic [AW:0]           occ [4];
	logic [3:0]            full;
	logic [3:0]            push;
	logic [3:0]            pop;

	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			empty[i] = (occ[i] == '0);
			full[i]  = (occ[i] == (AW+1)'(`DS_FIFO_DEPTH));
			push[i]  = fill_write && (fill_section == 2'(i)) && !full[i];  // Full section drops the write
			pop[i]   = lsab_read && (lsab_section == 2'(i)) && !empty[i];
		end
	end

	// Only one section is written per cycle
	always_ff @(posedge CLK)
	begin
		if (|push)
			mem[fill_section][wr_ptr[fill_section]] <= fill_data;
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			for (int i = 0; i < 4; i++)
			begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				occ[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (push[i])
					wr_ptr[i] <= wr_ptr[i] + 1'b1;  // Depth is a power of two so pointers wrap
				if (pop[i])
					rd_ptr[i] <= rd_ptr[i] + 1'b1;
				occ[i] <= occ[i] + (AW+1)'(push[i]) - (AW+1)'(pop[i]);
			end
		end
	end

	// Popped halfword appears one cycle after the read strobe
	always_ff @(posedge CLK)
	begin
		if (|pop)
			rd_data <= mem[lsab_section][rd_ptr[lsab_section]];
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
			rd_valid <= 1'b0;
		else
			rd_valid <= |pop;
	end

	// The mover must look at the empty flag before it reads
	a_no_read_empty: assert property (
		@(posedge CLK) disable iff (!RST)
		lsab_read |-> !empty[lsab_section]
	);

	// The fill agent must not overrun a section
	a_no_write_full: assert property (
		@(posedge CLK) disable iff (!RST)
		fill_write |-> !full[fill_section]
	);

endmodule

`default_nettype wire

// ==== hdl/dram_stage_pkg.sv ====
// Types shared by the staging RTL and its testbench, imported where a module needs them
`default_nettype none

`include "dram_stage_defs.svh"

package dram_stage_pkg;

	// Index of one of the four LSAB sections
	typedef logic [1:0] section_t;

	// One DRAM column seen two ways
	// The read side fills it a halfword at a time, the write side
	// stores it a byte at a time under the write mask.
	typedef union packed {
		logic [1:0][`DS_HALF_W-1:0] half;  // [1] is the odd halfword address, [0] the even one
		logic [3:0][7:0]            lane;  // Lane b is enabled by write mask bit b
	} column_u;

endpackage

`default_nettype wire

// ==== include/dram_stage_defs.svh ====
// Widths and sizes of the DRAM staging subsystem, included by every RTL and testbench file
`ifndef DRAM_STAGE_DEFS_SVH
`define DRAM_STAGE_DEFS_SVH

// One LSAB entry is a halfword
`define DS_HALF_W 16

// One DRAM column holds two halfwords, written as four masked bytes
`define DS_COL_W 32

// Halfword address; bit 0 picks the half inside a column
`define DS_ADDR_W 12

// Block count and count sent allow at most 31 halfwords per move
`define DS_COUNT_W 5

// Entries per LSAB section
`define DS_FIFO_DEPTH 32

// One column per even halfword address
`define DS_DRAM_COLS 2048

`endif
